//--- hdl/tlb_defs.svh
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

`default_nettype none

// Entry array geometry
`define TLB_NUM         16
`define TLB_IDX_LEN     4

// Field widths
`define TLB_VPPN_LEN    19      // VA[31:13]
`define TLB_VA_LEN      20      // VA[31:12]
`define TLB_PPN_LEN     20
`define TLB_ASID_LEN    10

// Page size codes, log2 of page bytes
`define TLB_PS_4K       12
`define TLB_PS_HUGE     21

// Direct mapping window CSR layout
`define DMW_VSEG_LSB    29
`define DMW_PSEG_LSB    25
`define DMW_MAT_BIT     4       // Low MAT bit, set means cached

`default_nettype wire

`endif

//--- hdl/tlb_pkg.sv
`include "tlb_defs.svh"

`default_nettype none

package tlb_pkg;

    // INVTLB op field
    typedef enum logic [4:0] {
        inv_all0      = 5'h00,
        inv_all1      = 5'h01,
        inv_global    = 5'h02,
        inv_nonglobal = 5'h03,
        inv_asid      = 5'h04,
        inv_asid_va   = 5'h05,
        inv_va_other  = 5'h06
    } tlb_inv_op_e;

    // Compare part of an entry
    typedef struct packed {
        logic                       e;
        logic [`TLB_ASID_LEN-1:0]   asid;
        logic                       g;
        logic [5:0]                 ps;
        logic [`TLB_VPPN_LEN-1:0]   vppn;
    } tlb_cpr_t;

    // One page half, even or odd
    typedef struct packed {
        logic                       v;
        logic                       d;
        logic [1:0]                 mat;
        logic [1:0]                 plv;
        logic [`TLB_PPN_LEN-1:0]    ppn;
    } tlb_trans_t;

endpackage

`default_nettype wire

//--- hdl/tlb_entry_array.sv
`timescale 1ns/1ps

`include "tlb_defs.svh"

`default_nettype none

module tlb_entry_array
    import tlb_pkg::*;
(
    input  logic                            clk,
    input  logic                            rstn,

    input  logic                            wr_strobe,
    input  logic [`TLB_IDX_LEN-1:0]         wr_index,
    input  tlb_cpr_t                        wr_cpr,
    input  tlb_trans_t                      wr_even,
    input  tlb_trans_t                      wr_odd,

    input  logic                            inv_strobe,
    input  tlb_inv_op_e                     inv_op,
    input  logic [`TLB_ASID_LEN-1:0]        inv_asid,
    input  logic [`TLB_VPPN_LEN-1:0]        inv_vppn,

    output tlb_cpr_t   [`TLB_NUM-1:0]       entry_cpr,
    output tlb_trans_t [`TLB_NUM-1:0]       entry_even,
    output tlb_trans_t [`TLB_NUM-1:0]       entry_odd
);

    localparam int HUGE_LOW = `TLB_PS_HUGE - `TLB_PS_4K;
    localparam logic [5:0] PS_HUGE = 6'(`TLB_PS_HUGE);

    logic [`TLB_NUM-1:0] asid_eq;
    logic [`TLB_NUM-1:0] vppn_eq;
    logic [`TLB_NUM-1:0] inv_hit;

    // Per entry qualifiers for the invalidate opcodes
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            asid_eq[i] = entry_cpr[i].asid == inv_asid;
            if (entry_cpr[i].ps == PS_HUGE) begin
                // Huge page spans 512 small VPPNs
                vppn_eq[i] = entry_cpr[i].vppn[`TLB_VPPN_LEN-1:HUGE_LOW]
                             == inv_vppn[`TLB_VPPN_LEN-1:HUGE_LOW];
            end else begin
                vppn_eq[i] = entry_cpr[i].vppn == inv_vppn;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            case (inv_op)
                inv_all0, inv_all1: inv_hit[i] = 1'b1;
                inv_global:         inv_hit[i] = entry_cpr[i].g;
                inv_nonglobal:      inv_hit[i] = ~entry_cpr[i].g;
                inv_asid:           inv_hit[i] = ~entry_cpr[i].g & asid_eq[i];
                inv_asid_va: begin
                    inv_hit[i] = ~entry_cpr[i].g & asid_eq[i] & vppn_eq[i];
                end
                inv_va_other: begin
                    inv_hit[i] = (entry_cpr[i].g | ~asid_eq[i]) & vppn_eq[i];
                end
                default:            inv_hit[i] = 1'b0;   // Reserved op
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            entry_cpr  <= '0;
            entry_even <= '0;
            entry_odd  <= '0;
        end else if (wr_strobe) begin
            // Write has priority over a same-cycle invalidate
            entry_cpr[wr_index]  <= wr_cpr;
            entry_even[wr_index] <= wr_even;
            entry_odd[wr_index]  <= wr_odd;
        end else if (inv_strobe) begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                if (inv_hit[i]) begin
                    entry_cpr[i].e <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/tlb_match.sv
`timescale 1ns/1ps

`include "tlb_defs.svh"

`default_nettype none

module tlb_match
    import tlb_pkg::*;
(
    input  logic [`TLB_VPPN_LEN-1:0]    vppn,
    input  logic [`TLB_ASID_LEN-1:0]    asid,
    input  tlb_cpr_t [`TLB_NUM-1:0]     entry_cpr,
    output logic [`TLB_NUM-1:0]         hit_vec
);

    localparam int HUGE_LOW = `TLB_PS_HUGE - `TLB_PS_4K;
    localparam logic [5:0] PS_HUGE = 6'(`TLB_PS_HUGE);

    for (genvar i = 0; i < `TLB_NUM; i++) begin : g_ent
        logic huge;
        logic hi_eq;
        logic lo_eq;
        logic asid_ok;

        assign huge = entry_cpr[i].ps == PS_HUGE;

        assign hi_eq = entry_cpr[i].vppn[`TLB_VPPN_LEN-1:HUGE_LOW]
                       == vppn[`TLB_VPPN_LEN-1:HUGE_LOW];
        assign lo_eq = entry_cpr[i].vppn[HUGE_LOW-1:0] == vppn[HUGE_LOW-1:0];

        assign asid_ok = entry_cpr[i].g | (entry_cpr[i].asid == asid);

        // Low bits don't care for huge pages
        assign hit_vec[i] = entry_cpr[i].e & asid_ok & hi_eq & (huge | lo_eq);
    end

endmodule

`default_nettype wire

//--- hdl/tlb_lookup.sv
`timescale 1ns/1ps

`include "tlb_defs.svh"

`default_nettype none

module tlb_lookup
    import tlb_pkg::*;
(
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            stall,

    input  logic                            va_valid,
    input  logic [`TLB_VA_LEN-1:0]          va,

    input  logic [`TLB_ASID_LEN-1:0]        csr_asid,
    input  logic                            csr_pg,
    input  logic                            csr_da_cached,
    input  logic [31:0]                     csr_dmw0,
    input  logic [31:0]                     csr_dmw1,

    input  tlb_cpr_t   [`TLB_NUM-1:0]       entry_cpr,
    input  tlb_trans_t [`TLB_NUM-1:0]       entry_even,
    input  tlb_trans_t [`TLB_NUM-1:0]       entry_odd,

    output logic                            pa_valid,
    output logic [`TLB_PPN_LEN-1:0]         pa,
    output logic                            pa_hit,
    output logic                            pa_page_valid,
    output logic                            pa_cached
);

    localparam int HUGE_LOW = `TLB_PS_HUGE - `TLB_PS_4K;
    localparam logic [5:0] PS_HUGE = 6'(`TLB_PS_HUGE);
    localparam int SEG_LSB = `TLB_VA_LEN - 3;   // VA[31:29] within the VPN

    logic [`TLB_NUM-1:0] hit_vec;

    logic                               s1_valid;
    logic [`TLB_VA_LEN-1:0]             s1_va;
    logic [`TLB_NUM-1:0]                s1_hit;
    logic [`TLB_NUM-1:0]                s1_odd;
    logic [`TLB_NUM-1:0]                s1_huge;
    tlb_trans_t [`TLB_NUM-1:0]          s1_even_half;
    tlb_trans_t [`TLB_NUM-1:0]          s1_odd_half;

    tlb_trans_t                         half;
    logic [`TLB_PPN_LEN-1:0]            tlb_ppn;
    logic                               tlb_v;
    logic                               tlb_mat0;
    logic                               dmw0_hit;
    logic                               dmw1_hit;
    logic [`TLB_PPN_LEN-1:0]            pa_d;
    logic                               hit_d;
    logic                               pv_d;
    logic                               cached_d;

    tlb_match u_match (
        .vppn       (va[`TLB_VA_LEN-1:1]),
        .asid       (csr_asid),
        .entry_cpr  (entry_cpr),
        .hit_vec    (hit_vec)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            pa_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= va_valid;
            pa_valid <= s1_valid;
        end
    end

    // Stage 1 payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_va        <= va;
            s1_hit       <= hit_vec;
            s1_even_half <= entry_even;
            s1_odd_half  <= entry_odd;
            for (int i = 0; i < `TLB_NUM; i++) begin
                s1_huge[i] <= entry_cpr[i].ps == PS_HUGE;
                s1_odd[i]  <= (entry_cpr[i].ps == PS_HUGE) ? va[HUGE_LOW] : va[0];
            end
        end
    end

    // Pick the half of the matching entry
    always_comb begin
        half     = '0;
        tlb_ppn  = '0;
        tlb_v    = 1'b0;
        tlb_mat0 = 1'b0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (s1_hit[i]) begin
                half     = s1_odd[i] ? s1_odd_half[i] : s1_even_half[i];
                tlb_ppn  = half.ppn;
                tlb_v    = half.v;
                tlb_mat0 = half.mat[0];
                if (s1_huge[i]) begin
                    tlb_ppn[HUGE_LOW-1:0] = s1_va[HUGE_LOW-1:0];
                end
            end
        end
    end

    assign dmw0_hit = s1_va[`TLB_VA_LEN-1:SEG_LSB] == csr_dmw0[`DMW_VSEG_LSB +: 3];
    assign dmw1_hit = s1_va[`TLB_VA_LEN-1:SEG_LSB] == csr_dmw1[`DMW_VSEG_LSB +: 3];

    always_comb begin
        if (!csr_pg) begin
            pa_d     = s1_va;              // Direct mode
            cached_d = csr_da_cached;
            hit_d    = 1'b1;
            pv_d     = 1'b1;
        end else if (dmw0_hit) begin
            pa_d     = {csr_dmw0[`DMW_PSEG_LSB +: 3], s1_va[SEG_LSB-1:0]};
            cached_d = csr_dmw0[`DMW_MAT_BIT];
            hit_d    = 1'b1;
            pv_d     = 1'b1;
        end else if (dmw1_hit) begin
            pa_d     = {csr_dmw1[`DMW_PSEG_LSB +: 3], s1_va[SEG_LSB-1:0]};
            cached_d = csr_dmw1[`DMW_MAT_BIT];
            hit_d    = 1'b1;
            pv_d     = 1'b1;
        end else begin
            pa_d     = tlb_ppn;            // Zero on a miss
            cached_d = tlb_mat0;
            hit_d    = |s1_hit;
            pv_d     = tlb_v;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pa            <= pa_d;
            pa_hit        <= hit_d;
            pa_page_valid <= pv_d;
            pa_cached     <= cached_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/tlb_search.sv
`timescale 1ns/1ps

`include "tlb_defs.svh"

`default_nettype none

module tlb_search
    import tlb_pkg::*;
(
    input  logic                            clk,
    input  logic                            rstn,

    input  logic                            srch_strobe,
    input  logic [`TLB_VPPN_LEN-1:0]        srch_vppn,
    input  logic [`TLB_ASID_LEN-1:0]        srch_asid,
    input  tlb_cpr_t [`TLB_NUM-1:0]         entry_cpr,

    output logic                            srch_done,
    output logic                            srch_hit,
    output logic [`TLB_IDX_LEN-1:0]         srch_index
);

    logic [`TLB_NUM-1:0]        hit_vec;
    logic [`TLB_NUM-1:0]        hit_q;
    logic                       pend;
    logic [`TLB_IDX_LEN-1:0]    enc_idx;

    tlb_match u_match (
        .vppn       (srch_vppn),
        .asid       (srch_asid),
        .entry_cpr  (entry_cpr),
        .hit_vec    (hit_vec)
    );

    // Highest set bit wins
    always_comb begin
        enc_idx = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (hit_q[i]) begin
                enc_idx = i[`TLB_IDX_LEN-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pend       <= 1'b0;
            hit_q      <= '0;
            srch_done  <= 1'b0;
            srch_hit   <= 1'b0;
            srch_index <= '0;
        end else begin
            pend       <= srch_strobe;
            hit_q      <= srch_strobe ? hit_vec : '0;
            srch_done  <= pend;
            srch_hit   <= |hit_q;
            srch_index <= enc_idx;
        end
    end

endmodule

`default_nettype wire

//--- hdl/tlb_top.sv
`timescale 1ns/1ps

`include "tlb_defs.svh"

`default_nettype none

module tlb_top (
    input  logic                            clk,
    input  logic                            rstn,

    input  logic                            wr_strobe,
    input  logic [`TLB_IDX_LEN-1:0]         wr_index,
    input  tlb_pkg::tlb_cpr_t               wr_cpr,
    input  tlb_pkg::tlb_trans_t             wr_even,
    input  tlb_pkg::tlb_trans_t             wr_odd,

    input  logic                            inv_strobe,
    input  tlb_pkg::tlb_inv_op_e            inv_op,
    input  logic [`TLB_ASID_LEN-1:0]        inv_asid,
    input  logic [`TLB_VPPN_LEN-1:0]        inv_vppn,

    input  logic                            stall,
    input  logic                            va_valid,
    input  logic [`TLB_VA_LEN-1:0]          va,
    input  logic [`TLB_ASID_LEN-1:0]        csr_asid,
    input  logic                            csr_pg,
    input  logic                            csr_da_cached,
    input  logic [31:0]                     csr_dmw0,
    input  logic [31:0]                     csr_dmw1,

    output logic                            pa_valid,
    output logic [`TLB_PPN_LEN-1:0]         pa,
    output logic                            pa_hit,
    output logic                            pa_page_valid,
    output logic                            pa_cached,

    input  logic                            srch_strobe,
    input  logic [`TLB_VPPN_LEN-1:0]        srch_vppn,
    output logic                            srch_done,
    output logic                            srch_hit,
    output logic [`TLB_IDX_LEN-1:0]         srch_index
);

    tlb_pkg::tlb_cpr_t   [`TLB_NUM-1:0]     entry_cpr;
    tlb_pkg::tlb_trans_t [`TLB_NUM-1:0]     entry_even;
    tlb_pkg::tlb_trans_t [`TLB_NUM-1:0]     entry_odd;

    tlb_entry_array u_array (
        .clk        (clk),
        .rstn       (rstn),
        .wr_strobe  (wr_strobe),
        .wr_index   (wr_index),
        .wr_cpr     (wr_cpr),
        .wr_even    (wr_even),
        .wr_odd     (wr_odd),
        .inv_strobe (inv_strobe),
        .inv_op     (inv_op),
        .inv_asid   (inv_asid),
        .inv_vppn   (inv_vppn),
        .entry_cpr  (entry_cpr),
        .entry_even (entry_even),
        .entry_odd  (entry_odd)
    );

    tlb_lookup u_lookup (
        .clk            (clk),
        .rstn           (rstn),
        .stall          (stall),
        .va_valid       (va_valid),
        .va             (va),
        .csr_asid       (csr_asid),
        .csr_pg         (csr_pg),
        .csr_da_cached  (csr_da_cached),
        .csr_dmw0       (csr_dmw0),
        .csr_dmw1       (csr_dmw1),
        .entry_cpr      (entry_cpr),
        .entry_even     (entry_even),
        .entry_odd      (entry_odd),
        .pa_valid       (pa_valid),
        .pa             (pa),
        .pa_hit         (pa_hit),
        .pa_page_valid  (pa_page_valid),
        .pa_cached      (pa_cached)
    );

    // Search uses the current ASID
    tlb_search u_search (
        .clk            (clk),
        .rstn           (rstn),
        .srch_strobe    (srch_strobe),
        .srch_vppn      (srch_vppn),
        .srch_asid      (csr_asid),
        .entry_cpr      (entry_cpr),
        .srch_done      (srch_done),
        .srch_hit       (srch_hit),
        .srch_index     (srch_index)
    );

endmodule

`default_nettype wire

//--- verif/tlb_props.sv
`timescale 1ns/1ps

`default_nettype none

module tlb_props (
    input  logic    clk,
    input  logic    rstn,
    input  logic    stall,
    input  logic    va_valid,
    input  logic    pa_valid,
    input  logic    srch_strobe,
    input  logic    srch_done
);

    // Both result strobes stay low in reset
    a_quiet_in_reset: assert property (
        @(posedge clk) !rstn |-> (!pa_valid && !srch_done)
    ) else $error("result strobe high while reset is applied");

    a_quiet_after_reset: assert property (
        @(posedge clk) $rose(rstn) |-> (!pa_valid && !srch_done)
    ) else $error("result strobe high on the first edge after reset");

    // Search has a fixed two cycle latency
    a_srch_latency: assert property (
        @(posedge clk) disable iff (!rstn)
        srch_done == $past(srch_strobe, 2)
    ) else $error("srch_done does not follow srch_strobe by two cycles");

    // Two unstalled edges carry a translation to the output
    a_xlat_latency: assert property (
        @(posedge clk) disable iff (!rstn)
        ($past(va_valid, 2) && !$past(stall, 2) && !$past(stall, 1)) |-> pa_valid
    ) else $error("pa_valid missing two cycles after an unstalled va_valid");

endmodule

bind tlb_top tlb_props u_props (
    .clk         (clk),
    .rstn        (rstn),
    .stall       (stall),
    .va_valid    (va_valid),
    .pa_valid    (pa_valid),
    .srch_strobe (srch_strobe),
    .srch_done   (srch_done)
);

`default_nettype wire

//--- verif/tlb_tb.sv
`timescale 1ns/1ps

`include "tlb_defs.svh"

`default_nettype none

module tlb_tb
    import tlb_pkg::*;
();

    localparam logic [9:0] ASID_A  = 10'h005;
    localparam logic [9:0] ASID_B  = 10'h2a3;
    localparam logic [5:0] PS_4K   = 6'(`TLB_PS_4K);
    localparam logic [5:0] PS_HUGE = 6'(`TLB_PS_HUGE);

    logic clk;
    logic rstn;
    logic wr_strobe;
    logic [`TLB_IDX_LEN-1:0] wr_index;
    tlb_cpr_t wr_cpr;
    tlb_trans_t wr_even;
    tlb_trans_t wr_odd;
    logic inv_strobe;
    tlb_inv_op_e inv_op;
    logic [`TLB_ASID_LEN-1:0] inv_asid;
    logic [`TLB_VPPN_LEN-1:0] inv_vppn;
    logic stall;
    logic va_valid;
    logic [`TLB_VA_LEN-1:0] va;
    logic [`TLB_ASID_LEN-1:0] csr_asid;
    logic csr_pg;
    logic csr_da_cached;
    logic [31:0] csr_dmw0;
    logic [31:0] csr_dmw1;
    logic pa_valid;
    logic [`TLB_PPN_LEN-1:0] pa;
    logic pa_hit;
    logic pa_page_valid;
    logic pa_cached;
    logic srch_strobe;
    logic [`TLB_VPPN_LEN-1:0] srch_vppn;
    logic srch_done;
    logic srch_hit;
    logic [`TLB_IDX_LEN-1:0] srch_index;

    // Reference copy of the entry array
    tlb_cpr_t   m_cpr [`TLB_NUM];
    tlb_trans_t m_even [`TLB_NUM];
    tlb_trans_t m_odd [`TLB_NUM];

    logic [22:0] xlat_q [$];    // {hit, page valid, cached, pa}
    logic [4:0]  srch_q [$];    // {hit, index}
    int check_errs;
    int other_errs;

    tlb_top uut (.*);

    always #4 clk = ~clk;

    function automatic logic vppn_covers(int i, logic [18:0] vppn);
        if (m_cpr[i].ps == PS_HUGE) begin
            return m_cpr[i].vppn[18:9] == vppn[18:9];   // 2 MB page
        end
        return m_cpr[i].vppn == vppn;
    endfunction

    function automatic logic [4:0] model_match(logic [18:0] vppn, logic [9:0] asid);
        logic [4:0] r;
        r = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (m_cpr[i].e && (m_cpr[i].g || m_cpr[i].asid == asid) && vppn_covers(i, vppn)) begin
                r = {1'b1, 4'(i)};
            end
        end
        return r;
    endfunction

    function automatic logic [22:0] expect_xlat(logic [19:0] v);
        logic [4:0] m;
        logic huge;
        tlb_trans_t h;
        logic [19:0] p;
        if (!csr_pg) begin
            return {2'b11, csr_da_cached, v};
        end
        if (v[19:17] == csr_dmw0[`DMW_VSEG_LSB +: 3]) begin
            return {2'b11, csr_dmw0[`DMW_MAT_BIT], csr_dmw0[`DMW_PSEG_LSB +: 3], v[16:0]};
        end
        if (v[19:17] == csr_dmw1[`DMW_VSEG_LSB +: 3]) begin
            return {2'b11, csr_dmw1[`DMW_MAT_BIT], csr_dmw1[`DMW_PSEG_LSB +: 3], v[16:0]};
        end
        m = model_match(v[19:1], csr_asid);
        if (!m[4]) begin
            return '0;
        end
        huge = m_cpr[m[3:0]].ps == PS_HUGE;
        h = (huge ? v[9] : v[0]) ? m_odd[m[3:0]] : m_even[m[3:0]];
        p = h.ppn;
        if (huge) begin
            p[8:0] = v[8:0];
        end
        return {1'b1, h.v, h.mat[0], p};
    endfunction

    function automatic logic inv_qualifies(int i, tlb_inv_op_e op, logic [9:0] asid,
                                           logic [18:0] vppn);
        logic same_asid;
        logic same_va;
        same_asid = m_cpr[i].asid == asid;
        same_va = vppn_covers(i, vppn);
        case (op)
            inv_all0, inv_all1: return 1'b1;
            inv_global:         return m_cpr[i].g;
            inv_nonglobal:      return !m_cpr[i].g;
            inv_asid:           return !m_cpr[i].g && same_asid;
            inv_asid_va:        return !m_cpr[i].g && same_asid && same_va;
            inv_va_other:       return (m_cpr[i].g || !same_asid) && same_va;
            default:            return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] make_dmw(logic [2:0] vseg, logic [2:0] pseg, logic cached);
        return (32'(vseg) << `DMW_VSEG_LSB) | (32'(pseg) << `DMW_PSEG_LSB)
               | (32'(cached) << `DMW_MAT_BIT);
    endfunction

    // Index bits in the VPPN keep entries apart
    function automatic tlb_cpr_t random_cpr(int i);
        tlb_cpr_t c;
        c.e = 1'b1;
        c.g = (i % 4 == 1);
        c.asid = (i % 4 == 3) ? ASID_B : ASID_A;
        c.ps = (i % 4 == 2) ? PS_HUGE : PS_4K;
        c.vppn = {2'b00, (i % 4 == 2), 4'(i), 12'($urandom)};
        return c;
    endfunction

    function automatic logic [19:0] entry_va(int i, logic odd);
        logic [19:0] v;
        v = {m_cpr[i].vppn, odd};
        if (m_cpr[i].ps == PS_HUGE) begin
            v[9:0] = {odd, 9'($urandom)};
        end
        return v;
    endfunction

    function automatic void quiet();
        va_valid = 1'b0;
        srch_strobe = 1'b0;
        wr_strobe = 1'b0;
        inv_strobe = 1'b0;
    endfunction

    task automatic compare_field(input string name, input logic [19:0] got,
                                 input logic [19:0] want);
        assert (got === want) else begin
            check_errs++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, want);
        end
    endtask

    task automatic translate(input logic [19:0] v);
        int k;
        @(negedge clk);
        quiet();
        va_valid = 1'b1;
        va = v;
        k = 0;
        if ($urandom_range(3) == 0) begin
            k = $urandom_range(3, 1);
        end
        stall = (k != 0);
        repeat (k) @(negedge clk);
        stall = 1'b0;
        xlat_q.push_back(expect_xlat(v));
    endtask

    task automatic search(input logic [18:0] vppn);
        @(negedge clk);
        quiet();
        srch_strobe = 1'b1;
        srch_vppn = vppn;
        srch_q.push_back(model_match(vppn, csr_asid));
    endtask

    task automatic write_entry(input logic [3:0] idx, input tlb_cpr_t c, input tlb_trans_t ev,
                               input tlb_trans_t od, input logic with_inv);
        @(negedge clk);
        quiet();
        wr_strobe = 1'b1;
        wr_index = idx;
        wr_cpr = c;
        wr_even = ev;
        wr_odd = od;
        inv_strobe = with_inv;  // Paired flush loses to the write
        inv_op = inv_all0;
        m_cpr[idx] = c;
        m_even[idx] = ev;
        m_odd[idx] = od;
    endtask

    task automatic invalidate(input tlb_inv_op_e op, input logic [9:0] asid,
                              input logic [18:0] vppn);
        @(negedge clk);
        quiet();
        inv_strobe = 1'b1;
        inv_op = op;
        inv_asid = asid;
        inv_vppn = vppn;
        for (int i = 0; i < `TLB_NUM; i++) begin
            if (inv_qualifies(i, op, asid, vppn)) begin
                m_cpr[i].e = 1'b0;
            end
        end
    endtask

    task automatic drain();
        int t;
        @(negedge clk);
        quiet();
        stall = 1'b0;
        t = 0;
        while ((xlat_q.size() != 0 || srch_q.size() != 0) && t < 50) begin
            @(negedge clk);
            t++;
        end
        if (xlat_q.size() != 0 || srch_q.size() != 0) begin
            other_errs++;
            $display("Timed out waiting for outstanding results");
        end
    endtask

    task automatic fill_entries();
        for (int i = 0; i < `TLB_NUM; i++) begin
            write_entry(4'(i), random_cpr(i), tlb_trans_t'(26'($urandom)),
                        tlb_trans_t'(26'($urandom)), 1'b0);
        end
        drain();
    endtask

    // Both halves and a search of every entry, under both ASIDs
    task automatic check_all();
        for (int a = 0; a < 2; a++) begin
            drain();
            csr_asid = a[0] ? ASID_B : ASID_A;
            for (int i = 0; i < `TLB_NUM; i++) begin
                translate(entry_va(i, 1'b0));
                translate(entry_va(i, 1'b1));
                search(m_cpr[i].vppn);
            end
        end
        drain();
    endtask

    always @(posedge clk) begin : check_xlat
        logic [22:0] want;
        if (rstn && pa_valid && !stall) begin
            if (xlat_q.size() == 0) begin
                other_errs++;
                $display("Translation result appeared with none outstanding");
            end else begin
                want = xlat_q.pop_front();
                compare_field("pa", pa, want[19:0]);
                compare_field("pa_hit", 20'(pa_hit), 20'(want[22]));
                compare_field("pa_page_valid", 20'(pa_page_valid), 20'(want[21]));
                compare_field("pa_cached", 20'(pa_cached), 20'(want[20]));
            end
        end
    end

    always @(posedge clk) begin : check_srch
        logic [4:0] want;
        if (rstn && srch_done) begin
            if (srch_q.size() == 0) begin
                other_errs++;
                $display("Search result appeared with none outstanding");
            end else begin
                want = srch_q.pop_front();
                compare_field("srch_hit", 20'(srch_hit), 20'(want[4]));
                compare_field("srch_index", 20'(srch_index), 20'(want[3:0]));
            end
        end
    end

    initial begin : watchdog
        #1_000_000;
        $display("Simulation did not finish in time");
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hb847_73ee));
        clk = 1'b0;
        rstn = 1'b0;
        quiet();
        wr_index = '0;
        wr_cpr = '0;
        wr_even = '0;
        wr_odd = '0;
        inv_op = inv_all0;
        inv_asid = '0;
        inv_vppn = '0;
        stall = 1'b0;
        va = '0;
        srch_vppn = '0;
        csr_asid = ASID_A;
        csr_pg = 1'b0;
        csr_da_cached = 1'b0;
        csr_dmw0 = '0;
        csr_dmw1 = '0;
        check_errs = 0;
        other_errs = 0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            m_cpr[i] = '0;
            m_even[i] = '0;
            m_odd[i] = '0;
        end
        repeat (2) @(negedge clk);
        rstn = 1'b1;

        for (int n = 0; n < 16; n++) begin
            translate(20'($urandom));
            if (n == 7) begin
                drain();
                csr_da_cached = 1'b1;
            end
        end
        drain();

        // Windows, then window 0 over window 1
        csr_pg = 1'b1;
        csr_dmw0 = make_dmw(3'b101, 3'b000, 1'b1);
        csr_dmw1 = make_dmw(3'b100, 3'b011, 1'b0);
        for (int n = 0; n < 4; n++) begin
            translate({3'b101, 17'($urandom)});
            translate({3'b100, 17'($urandom)});
            translate({3'b000, 17'($urandom)});
        end
        drain();
        csr_dmw0 = make_dmw(3'b110, 3'b001, 1'b0);
        csr_dmw1 = make_dmw(3'b110, 3'b010, 1'b1);
        for (int n = 0; n < 4; n++) begin
            translate({3'b110, 17'($urandom)});
        end
        drain();

        // Paged, with windows parked where no entry lives
        csr_dmw0 = make_dmw(3'b111, 3'b000, 1'b0);
        csr_dmw1 = make_dmw(3'b111, 3'b001, 1'b0);
        fill_entries();
        check_all();
        for (int n = 0; n < 8; n++) begin
            translate({3'b010, 17'($urandom)});
            search({2'b10, 17'($urandom)});
        end
        drain();

        for (int op = 0; op < 8; op++) begin
            fill_entries();
            invalidate(tlb_inv_op_e'(5'(op)), ASID_A, (op == 6) ? m_cpr[3].vppn : m_cpr[0].vppn);
            drain();
            check_all();
        end

        fill_entries();
        write_entry(4'd4, random_cpr(4), tlb_trans_t'(26'($urandom)),
                    tlb_trans_t'(26'($urandom)), 1'b1);
        drain();
        check_all();

        $display("Errors: %0d check, %0d other", check_errs, other_errs);
        if (check_errs == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tlb_top.f
+incdir+hdl
hdl/tlb_pkg.sv
hdl/tlb_entry_array.sv
hdl/tlb_match.sv
hdl/tlb_lookup.sv
hdl/tlb_search.sv
hdl/tlb_top.sv
verif/tlb_props.sv
verif/tlb_tb.sv

//--- Makefile
SIM       = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tlb_tb
FLIST     = tlb_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Regression failed
PASS_MSG  = Regression passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
